// ==== Bender.yml ====
package:
  name: data_cache

sources:
  - hdl/cache_cfg_pkg.sv
  - hdl/burst_ram_pkg.sv
  - hdl/burst_req_if.sv
  - hdl/line_beat_if.sv
  - hdl/cache_ctrl.sv
  - hdl/line_store.sv
  - hdl/burst_engine.sv
  - hdl/data_cache.sv
  - target: test
    files:
      - dv/burst_ram_model.sv
      - dv/data_cache_tb.sv

// ==== dv/burst_ram_model.sv ====
// ====================================================================
// behavioral burst RAM with random read latency, command counters
// and a memory that the testbench can inspect
// ====================================================================
`default_nettype none

module burst_ram_model
  import burst_ram_pkg::*;
#(
  parameter int unsigned seed = 32'h1
) (
  input  wire                      clk,
  input  wire                      br_cmd,
  input  wire                      br_cmd_en,
  input  wire [ram_addr_bits-1:0]  br_addr,
  input  wire [beat_bits-1:0]      br_wr_data,
  output logic [beat_bits-1:0]     br_rd_data,
  output logic                     br_rd_data_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // one entry per beat, low word at the lower byte address
  logic [beat_bits-1:0]     mem [2**ram_addr_bits];
  int                       read_count;
  int                       write_count;
  logic [ram_addr_bits-1:0] last_rd_addr;
  logic [ram_addr_bits-1:0] last_wr_addr;
  logic                     last_cmd;

  // preload value, every address bit takes part
  function automatic logic [31:0] word_pattern(input logic [31:0] byte_addr);
    return (byte_addr * 32'h0101_0101) ^ 32'h5ac3_3ca5;
  endfunction

  initial begin
    int unsigned              lat;
    logic [ram_addr_bits-1:0] base;
    void'($urandom(seed));
    br_rd_data = '0;
    br_rd_data_valid = 1'b0;
    read_count = 0;
    write_count = 0;
    last_rd_addr = '0;
    last_wr_addr = '0;
    last_cmd = ram_cmd_read;
    for (int i = 0; i < 2**ram_addr_bits; i++) begin
      mem[i] = {word_pattern(32'(i * 8 + 4)), word_pattern(32'(i * 8))};
    end
    forever begin
      @(posedge clk);
      if (br_cmd_en === 1'b1) begin
        base = br_addr;
        last_cmd = br_cmd;
        if (br_cmd == ram_cmd_write) begin
          write_count++;
          last_wr_addr = base;
          // beat 0 comes with the command, the rest back to back
          mem[base] = br_wr_data;
          for (int b = 1; b < beats_per_line; b++) begin
            @(posedge clk);
            mem[base + b] = br_wr_data;
          end
        end else begin
          read_count++;
          last_rd_addr = base;
          // 1 to 6 idle cycles before the first beat
          lat = 1 + ($urandom % 6);
          repeat (lat) @(posedge clk);
          for (int b = 0; b < beats_per_line; b++) begin
            #1;
            br_rd_data = mem[base + b];
            br_rd_data_valid = 1'b1;
            @(posedge clk);
          end
          #1;
          br_rd_data_valid = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/data_cache_tb.sv ====
// ====================================================================
// data cache testbench: clock, reset, stimulus table, shadow memory
// and checks of the requester and RAM sides
// ====================================================================
`default_nettype none

module data_cache_tb
  import burst_ram_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] no_victim = 32'hffff_ffff;
  localparam int wait_limit = 200;

  typedef struct packed {
    logic        cmd;
    logic [31:0] addr;
    logic [3:0]  bytes;
    logic [31:0] data;
    logic        hit;
    logic [31:0] victim;
  } row_t;

  // command, address, byte enables, data, hit expected, evicted line
  localparam row_t rows [15] = '{
    '{1'b0, 32'h0000_0004, 4'b0000, 32'h0000_0000, 1'b0, no_victim},
    '{1'b0, 32'h0000_001c, 4'b0000, 32'h0000_0000, 1'b1, no_victim},
    '{1'b1, 32'h0000_0008, 4'b0101, 32'hdead_beef, 1'b1, no_victim},
    '{1'b0, 32'h0000_0008, 4'b0000, 32'h0000_0000, 1'b1, no_victim},
    // same line index, other tag, dirty victim goes out first
    '{1'b0, 32'h0000_0408, 4'b0000, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{1'b0, 32'h0000_0008, 4'b0000, 32'h0000_0000, 1'b0, no_victim},
    // write miss into the empty line 1
    '{1'b1, 32'h0000_0024, 4'b1100, 32'h1234_5678, 1'b0, no_victim},
    '{1'b0, 32'h0000_0024, 4'b0000, 32'h0000_0000, 1'b1, no_victim},
    '{1'b1, 32'h0000_003c, 4'b1111, 32'hcafe_f00d, 1'b1, no_victim},
    '{1'b0, 32'h0000_07e4, 4'b0000, 32'h0000_0000, 1'b0, 32'h0000_0020},
    '{1'b0, 32'h0000_003c, 4'b0000, 32'h0000_0000, 1'b0, no_victim},
    '{1'b1, 32'h0000_0000, 4'b0010, 32'h00a5_5a00, 1'b1, no_victim},
    '{1'b0, 32'h0000_0000, 4'b0000, 32'h0000_0000, 1'b1, no_victim},
    '{1'b0, 32'h0000_0440, 4'b0000, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{1'b0, 32'h0000_0000, 4'b0000, 32'h0000_0000, 1'b0, no_victim}
  };

  logic                     clk;
  logic                     rst;
  logic                     enable;
  logic                     command;
  logic [31:0]              address;
  logic [3:0]               write_enable_bytes;
  logic [31:0]              data_in;
  logic [31:0]              data_out;
  logic                     data_out_ready;
  logic                     busy;
  logic                     br_cmd;
  logic                     br_cmd_en;
  logic [ram_addr_bits-1:0] br_addr;
  logic [beat_bits-1:0]     br_wr_data;
  logic [beat_bits-1:0]     br_rd_data;
  logic                     br_rd_data_valid;

  // expected contents of the whole 2 KB, one entry per word
  logic [31:0] shadow [512];

  data_cache #(.line_ix_bits(1)) UUT (.*);

  burst_ram_model #(.seed(32'he787b8b1)) ram (.*);

  function automatic logic [31:0] word_pattern(input logic [31:0] byte_addr);
    return (byte_addr * 32'h0101_0101) ^ 32'h5ac3_3ca5;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Something failed");
      $fatal(1, "stopped at the first error");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s at %0t ns", why, $time);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  // entered on a falling edge with busy high
  task automatic wait_busy_low();
    int n;
    n = 0;
    while (busy && n < wait_limit) begin
      check_value("data_out_ready", data_out_ready, 1'b0);
      @(negedge clk);
      n++;
    end
    if (busy) begin
      abort_run("timeout, busy never fell after a miss");
    end
  endtask

  // every word of an evicted line must now sit in the RAM
  task automatic compare_ram_line(input logic [31:0] line_addr);
    logic [31:0] a;
    for (int w = 0; w < 8; w++) begin
      a = {line_addr[31:5], 5'b0} + 32'(4 * w);
      check_value("ram word", ram.mem[a[10:3]][32*a[2] +: 32], shadow[a[10:2]]);
    end
  endtask

  task automatic apply_row(input row_t r);
    int          rd_before;
    int          wr_before;
    logic [31:0] expect_word;
    rd_before = ram.read_count;
    wr_before = ram.write_count;
    if (r.cmd) begin
      for (int b = 0; b < 4; b++) begin
        if (r.bytes[b]) begin
          shadow[r.addr[10:2]][8*b +: 8] = r.data[8*b +: 8];
        end
      end
    end
    expect_word = shadow[r.addr[10:2]];
    @(posedge clk);
    #1;
    enable = 1'b1;
    command = r.cmd;
    address = r.addr;
    write_enable_bytes = r.bytes;
    data_in = r.data;
    // busy is low here, so this edge accepts the request
    @(posedge clk);
    #1;
    enable = 1'b0;
    // hit check cycle
    @(negedge clk);
    check_value("busy", busy, 1'b0);
    check_value("data_out_ready", data_out_ready, 1'b0);
    @(negedge clk);
    if (r.hit) begin
      check_value("busy", busy, 1'b0);
      check_value("ram.read_count", ram.read_count, rd_before);
    end else begin
      check_value("busy", busy, 1'b1);
      wait_busy_low();
      check_value("ram.read_count", ram.read_count, rd_before + 1);
      check_value("ram.last_rd_addr", ram.last_rd_addr, {r.addr[10:5], 2'b00});
      // the fill is always the last command of a miss
      check_value("ram.last_cmd", ram.last_cmd, ram_cmd_read);
    end
    check_value("data_out_ready", data_out_ready, !r.cmd);
    if (!r.cmd) begin
      check_value("data_out", data_out, expect_word);
    end
    if (!r.hit && r.victim != no_victim) begin
      check_value("ram.write_count", ram.write_count, wr_before + 1);
      check_value("ram.last_wr_addr", ram.last_wr_addr, {r.victim[10:5], 2'b00});
      compare_ram_line(r.victim);
    end else begin
      check_value("ram.write_count", ram.write_count, wr_before);
    end
    // single cycle result pulse
    @(negedge clk);
    check_value("data_out_ready", data_out_ready, 1'b0);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    enable = 1'b0;
    command = 1'b0;
    address = '0;
    write_enable_bytes = '0;
    data_in = '0;
    for (int i = 0; i < 512; i++) begin
      shadow[i] = word_pattern(32'(i * 4));
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_value("busy", busy, 1'b0);
    check_value("data_out_ready", data_out_ready, 1'b0);
    check_value("br_cmd_en", br_cmd_en, 1'b0);
    for (int i = 0; i < 15; i++) begin
      apply_row(rows[i]);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/cache_cfg_pkg.sv
hdl/burst_ram_pkg.sv
hdl/burst_req_if.sv
hdl/line_beat_if.sv
hdl/cache_ctrl.sv
hdl/line_store.sv
hdl/burst_engine.sv
hdl/data_cache.sv
dv/burst_ram_model.sv
dv/data_cache_tb.sv

// ==== hdl/burst_engine.sv ====
// ====================================================================
// burst engine: beat counter and RAM signalling for write-back and
// fill bursts
// ====================================================================
`default_nettype none

module burst_engine
  import burst_ram_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst,
  burst_req_if.engine              req,
  line_beat_if.engine              beat,
  output logic                     br_cmd,
  output logic                     br_cmd_en,
  output logic [ram_addr_bits-1:0] br_addr,
  output logic [beat_bits-1:0]     br_wr_data,
  input  wire [beat_bits-1:0]      br_rd_data,
  input  wire                      br_rd_data_valid
);

  logic                    active;
  logic                    wr;
  logic [beat_ix_bits-1:0] beat_cnt;
  logic                    beat_step;
  logic                    last_beat;

  // write beats run back to back from the command cycle on
  // fill beats advance on each valid beat from the RAM
  assign beat_step = active && (wr || br_rd_data_valid);
  assign last_beat = (beat_cnt == beat_ix_bits'(beats_per_line - 1));

  assign beat.beat_ix = beat_cnt;
  assign beat.fill_en = active && !wr && br_rd_data_valid;
  assign beat.fill_data = br_rd_data;

  // beat 0 goes out together with br_cmd_en
  assign br_wr_data = beat.evict_data;
  assign br_cmd = wr ? ram_cmd_write : ram_cmd_read;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      wr <= 1'b0;
      beat_cnt <= '0;
      br_cmd_en <= 1'b0;
      req.done <= 1'b0;
    end else begin
      br_cmd_en <= req.start;
      req.done <= beat_step && last_beat;
      if (req.start) begin
        active <= 1'b1;
        wr <= req.write;
        beat_cnt <= '0;
      end else if (beat_step) begin
        beat_cnt <= beat_cnt + 1'b1;
        if (last_beat) begin
          active <= 1'b0;
        end
      end
    end
  end

  // command address is held for the whole burst
  always_ff @(posedge clk) begin
    if (req.start) begin
      br_addr <= req.ram_addr;
    end
  end

  rd_valid_in_fill: assert property (
    @(posedge clk) disable iff (rst) br_rd_data_valid |-> active && !wr
  );

  cmd_en_single: assert property (
    @(posedge clk) disable iff (rst) br_cmd_en |=> !br_cmd_en
  );

endmodule

`default_nettype wire

// ==== hdl/burst_ram_pkg.sv ====
// ====================================================================
// burst RAM beat format, burst length, address width and commands
// ====================================================================
`default_nettype none

package burst_ram_pkg;

  // one beat is two cache words
  localparam int beat_bits = 64;
  localparam int words_per_beat = 2;

  // one burst moves one cache line
  localparam int beats_per_line = 4;
  localparam int beat_ix_bits = 2;

  // beat addressed, 256 beats of 8 bytes
  localparam int ram_addr_bits = 8;

  // br_cmd encodings
  localparam logic ram_cmd_read = 1'b0;
  localparam logic ram_cmd_write = 1'b1;

endpackage

`default_nettype wire

// ==== hdl/burst_req_if.sv ====
// ====================================================================
// line transfer requests from the cache controller to the burst engine
// ====================================================================
`default_nettype none

interface burst_req_if
  import burst_ram_pkg::*;
();

  // one cycle pulse, only while no burst is running
  logic start;
  // 1 write-back, 0 fill
  logic write;
  // line aligned beat address, low beat index bits zero
  logic [ram_addr_bits-1:0] ram_addr;
  // one cycle pulse in the cycle after the last beat
  logic done;

  modport ctrl (
    output start,
    output write,
    output ram_addr,
    input  done
  );

  modport engine (
    input  start,
    input  write,
    input  ram_addr,
    output done
  );

endinterface

`default_nettype wire

// ==== hdl/cache_cfg_pkg.sv ====
// ====================================================================
// cache geometry constants and the byte address union shared by
// the controller and the data array
// ====================================================================
`default_nettype none

package cache_cfg_pkg;

  // one data word and its byte enables
  localparam int word_bits = 32;
  localparam int word_bytes = 4;

  // eight words per line, 32 bytes
  localparam int words_per_line = 8;
  localparam int word_ix_bits = 3;

  // word aligned access, low bits always zero
  localparam int byte_off_bits = 2;

  localparam int addr_bits = 32;
  // tag and line index together
  localparam int line_addr_bits = addr_bits - word_ix_bits - byte_off_bits;

  // one byte address, seen either from the cache side or the RAM side
  typedef union packed {
    // the controller splits line_addr into tag and line index
    struct packed {
      logic [line_addr_bits-1:0] line_addr;
      logic [word_ix_bits-1:0]   word_ix;
      logic [byte_off_bits-1:0]  byte_off;
    } cache_view;
    // ram_line with beat_ix is the 8 bit beat address of the burst RAM
    struct packed {
      logic [20:0] unused;
      logic [5:0]  ram_line;
      logic [1:0]  beat_ix;
      logic        word_sel;
      logic [1:0]  byte_off;
    } ram_view;
  } cache_addr_t;

endpackage

`default_nettype wire

// ==== hdl/cache_ctrl.sv ====
// ====================================================================
// cache controller: request latch, tag/valid/dirty store, hit check,
// miss sequencing and the read result register
// ====================================================================
`default_nettype none

module cache_ctrl
  import cache_cfg_pkg::*;
  import burst_ram_pkg::*;
#(
  parameter int line_ix_bits = 1
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     enable,
  input  wire                     command,
  input  wire cache_addr_t        address,
  input  wire [word_bytes-1:0]    write_enable_bytes,
  input  wire [word_bits-1:0]     data_in,
  output logic [word_bits-1:0]    data_out,
  output logic                    data_out_ready,
  output logic                    busy,
  burst_req_if.ctrl               req,
  output logic [line_ix_bits-1:0] word_line_ix,
  output logic [word_ix_bits-1:0] word_ix,
  output logic [word_bytes-1:0]   word_wr_bytes,
  output logic [word_bits-1:0]    word_wr_data,
  input  wire [word_bits-1:0]     word_rd_data
);

  localparam int lines = 2 ** line_ix_bits;
  localparam int tag_bits = line_addr_bits - line_ix_bits;

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_wb = 2'd1;
  localparam logic [1:0] st_fill = 2'd2;

  logic [1:0] state;
  // latched request waits one cycle for its hit check
  logic       check;

  cache_addr_t           req_addr;
  logic                  req_write;
  logic [word_bytes-1:0] req_bytes;
  logic [word_bits-1:0]  req_data;

  logic [lines-1:0]    valid_q;
  logic [lines-1:0]    dirty_q;
  logic [tag_bits-1:0] tag_q [lines];

  logic [line_ix_bits-1:0]  line_ix;
  logic [tag_bits-1:0]      req_tag;
  logic                     hit;
  logic                     accept;
  logic                     fill_end;
  logic                     serve;
  cache_addr_t              victim_addr;
  logic [ram_addr_bits-1:0] fill_ram_addr;
  logic [ram_addr_bits-1:0] evict_ram_addr;

  // |tag|line_ix| inside the line address
  assign line_ix = req_addr.cache_view.line_addr[line_ix_bits-1:0];
  assign req_tag = req_addr.cache_view.line_addr[line_addr_bits-1 -: tag_bits];
  assign hit = valid_q[line_ix] && (tag_q[line_ix] == req_tag);

  assign busy = (state != st_idle);
  // a miss still in its check cycle blocks the next request
  assign accept = enable && !busy && !(check && !hit);
  assign fill_end = (state == st_fill) && req.done;
  // cycle in which the latched request is read or merged
  assign serve = (check && hit) || fill_end;

  // victim line rebuilt from its stored tag
  always_comb begin
    victim_addr = '0;
    victim_addr.cache_view.line_addr = {tag_q[line_ix], line_ix};
  end

  assign fill_ram_addr = {req_addr.ram_view.ram_line, {beat_ix_bits{1'b0}}};
  assign evict_ram_addr = {victim_addr.ram_view.ram_line, {beat_ix_bits{1'b0}}};

  // word port, line index also selects the line for the bursts
  assign word_line_ix = line_ix;
  assign word_ix = req_addr.cache_view.word_ix;
  assign word_wr_data = req_data;
  assign word_wr_bytes = (serve && req_write) ? req_bytes : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      check <= 1'b0;
      valid_q <= '0;
      dirty_q <= '0;
      data_out_ready <= 1'b0;
      req.start <= 1'b0;
    end else begin
      check <= accept;
      req.start <= 1'b0;
      data_out_ready <= serve && !req_write;
      case (state)
        st_idle: begin
          if (check && !hit) begin
            req.start <= 1'b1;
            // dirty victim goes out first
            state <= dirty_q[line_ix] ? st_wb : st_fill;
          end
        end
        st_wb: begin
          if (req.done) begin
            req.start <= 1'b1;
            state <= st_fill;
          end
        end
        st_fill: begin
          if (req.done) begin
            valid_q[line_ix] <= 1'b1;
            dirty_q[line_ix] <= 1'b0;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
      // writes mark the line dirty, also after a fill
      if (serve && req_write) begin
        dirty_q[line_ix] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr <= address;
      req_write <= command;
      req_bytes <= write_enable_bytes;
      req_data <= data_in;
    end
    if (serve && !req_write) begin
      data_out <= word_rd_data;
    end
    if (fill_end) begin
      tag_q[line_ix] <= req_tag;
    end
    if (state == st_idle && check && !hit) begin
      req.write <= dirty_q[line_ix];
      req.ram_addr <= dirty_q[line_ix] ? evict_ram_addr : fill_ram_addr;
    end else if (state == st_wb && req.done) begin
      req.write <= 1'b0;
      req.ram_addr <= fill_ram_addr;
    end
  end

  // one burst at a time, the next start only after done
  start_after_done: assert property (
    @(posedge clk) disable iff (rst) req.start |=> !req.start until req.done
  );

  no_result_while_busy: assert property (
    @(posedge clk) disable iff (rst) data_out_ready |-> !busy
  );

endmodule

`default_nettype wire

// ==== hdl/data_cache.sv ====
// ====================================================================
// write-back data cache top level in front of a burst RAM
// ====================================================================
`default_nettype none

module data_cache
  import burst_ram_pkg::*;
#(
  parameter int line_ix_bits = 1
) (
  input  wire                      clk,
  input  wire                      rst,
  // requester side
  input  wire                      enable,
  input  wire                      command,
  input  wire [31:0]               address,
  input  wire [3:0]                write_enable_bytes,
  input  wire [31:0]               data_in,
  output logic [31:0]              data_out,
  output logic                     data_out_ready,
  output logic                     busy,
  // burst RAM side
  output logic                     br_cmd,
  output logic                     br_cmd_en,
  output logic [ram_addr_bits-1:0] br_addr,
  output logic [beat_bits-1:0]     br_wr_data,
  input  wire [beat_bits-1:0]      br_rd_data,
  input  wire                      br_rd_data_valid
);

  // word port between controller and data array
  logic [line_ix_bits-1:0] word_line_ix;
  logic [2:0]              word_ix;
  logic [3:0]              word_wr_bytes;
  logic [31:0]             word_wr_data;
  logic [31:0]             word_rd_data;

  burst_req_if req_bus ();
  line_beat_if beat_bus ();

  cache_ctrl #(
    .line_ix_bits(line_ix_bits)
  ) u_ctrl (
    .clk               (clk),
    .rst               (rst),
    .enable            (enable),
    .command           (command),
    .address           (address),
    .write_enable_bytes(write_enable_bytes),
    .data_in           (data_in),
    .data_out          (data_out),
    .data_out_ready    (data_out_ready),
    .busy              (busy),
    .req               (req_bus.ctrl),
    .word_line_ix      (word_line_ix),
    .word_ix           (word_ix),
    .word_wr_bytes     (word_wr_bytes),
    .word_wr_data      (word_wr_data),
    .word_rd_data      (word_rd_data)
  );

  line_store #(
    .line_ix_bits(line_ix_bits)
  ) u_store (
    .clk          (clk),
    .word_line_ix (word_line_ix),
    .word_ix      (word_ix),
    .word_wr_bytes(word_wr_bytes),
    .word_wr_data (word_wr_data),
    .word_rd_data (word_rd_data),
    .beat         (beat_bus.store)
  );

  burst_engine u_engine (
    .clk             (clk),
    .rst             (rst),
    .req             (req_bus.engine),
    .beat            (beat_bus.engine),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

endmodule

`default_nettype wire

// ==== hdl/line_beat_if.sv ====
// ====================================================================
// beat wide data path between the burst engine and the line storage
// ====================================================================
`default_nettype none

interface line_beat_if
  import burst_ram_pkg::*;
();

  // beat of the current line being moved
  logic [beat_ix_bits-1:0] beat_ix;
  // write fill_data into beat beat_ix
  logic                    fill_en;
  logic [beat_bits-1:0]    fill_data;
  // contents of beat beat_ix, no register in between
  logic [beat_bits-1:0]    evict_data;

  modport engine (
    output beat_ix,
    output fill_en,
    output fill_data,
    input  evict_data
  );

  modport store (
    input  beat_ix,
    input  fill_en,
    input  fill_data,
    output evict_data
  );

endinterface

`default_nettype wire

// ==== hdl/line_store.sv ====
// ====================================================================
// cache data array with a word port and a beat port
// ====================================================================
`default_nettype none

module line_store
  import cache_cfg_pkg::*;
  import burst_ram_pkg::*;
#(
  parameter int line_ix_bits = 1
) (
  input  wire                     clk,
  input  wire [line_ix_bits-1:0]  word_line_ix,
  input  wire [word_ix_bits-1:0]  word_ix,
  input  wire [word_bytes-1:0]    word_wr_bytes,
  input  wire [word_bits-1:0]     word_wr_data,
  output logic [word_bits-1:0]    word_rd_data,
  line_beat_if.store              beat
);

  localparam int lines = 2 ** line_ix_bits;

  // lines x words of cached data
  logic [word_bits-1:0] data_q [lines][words_per_line];

  always_ff @(posedge clk) begin
    // byte merge from the word port
    for (int b = 0; b < word_bytes; b++) begin
      if (word_wr_bytes[b]) begin
        data_q[word_line_ix][word_ix][8*b +: 8] <= word_wr_data[8*b +: 8];
      end
    end
    // fill beat, low word first
    if (beat.fill_en) begin
      for (int w = 0; w < words_per_beat; w++) begin
        data_q[word_line_ix][beat.beat_ix * words_per_beat + w]
          <= beat.fill_data[word_bits*w +: word_bits];
      end
    end
  end

  assign word_rd_data = data_q[word_line_ix][word_ix];

  // eviction beat of the same line, combinational
  always_comb begin
    for (int w = 0; w < words_per_beat; w++) begin
      beat.evict_data[word_bits*w +: word_bits] =
        data_q[word_line_ix][beat.beat_ix * words_per_beat + w];
    end
  end

  // controller merges only outside fill beats
  no_fill_word_clash: assert property (
    @(posedge clk) !(beat.fill_en && (|word_wr_bytes))
  );

endmodule

`default_nettype wire
